// ==== src/htable_pkg.sv ====
package htable_pkg;

    // ---------------------------------------------------------------------
    // Table geometry
    // ---------------------------------------------------------------------

    // Key and value widths as stored in a slot
    localparam int KEY_W      = 16;
    localparam int VALUE_W    = 16;

    // Slot index width, the hash folds the key down to this
    localparam int HASH_W     = 8;

    // One slot per hash value
    localparam int TABLE_SIZE = 2 ** HASH_W;

    // ---------------------------------------------------------------------
    // Basic types
    // ---------------------------------------------------------------------
    typedef logic [KEY_W-1:0]   key_t;
    typedef logic [VALUE_W-1:0] value_t;
    typedef logic [HASH_W-1:0]  hash_t;

    // Content of one slot
    // Full key kept so that collisions read as misses
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } entry_t;

endpackage : htable_pkg

// ==== src/db_pkg.sv ====
package db_pkg;

    // ---------------------------------------------------------------------
    // Encodings
    // ---------------------------------------------------------------------

    // Update channel opcode
    typedef enum logic {
        OP_INSERT = 1'b0,
        OP_DELETE = 1'b1
    } op_e;

    // Controller states
    typedef enum logic [1:0] {
        ST_RESET = 2'd0,
        ST_INIT  = 2'd1,
        ST_RUN   = 2'd2
    } ctrl_state_e;

    // ---------------------------------------------------------------------
    // Transaction structs
    // ---------------------------------------------------------------------

    // Update request, qualified by upd_req
    typedef struct packed {
        op_e               op;
        htable_pkg::key_t   key;
        htable_pkg::value_t value;
    } update_req_t;

    // Lookup request, qualified by lkp_req
    typedef struct packed {
        htable_pkg::key_t key;
    } lookup_req_t;

    // Lookup response, qualified by lkp_ack
    typedef struct packed {
        logic               hit;
        htable_pkg::value_t value;
    } lookup_resp_t;

    // Memory write port
    typedef struct packed {
        htable_pkg::hash_t  addr;
        htable_pkg::entry_t data;
    } mem_wr_t;

endpackage : db_pkg

// ==== src/htable_hash.sv ====
`timescale 1ns/10ps

module htable_hash (
    input  logic                clk,
    input  logic                arst_n,
    // Request in
    input  logic                in_req,
    input  htable_pkg::key_t    in_key,
    input  db_pkg::update_req_t in_ctx,
    // Hashed request out, one cycle later
    output logic                out_req,
    output htable_pkg::hash_t   out_hash,
    output db_pkg::update_req_t out_ctx
);
    import htable_pkg::*;

    hash_t fold;

    // High key byte folded onto low key byte
    assign fold = in_key[KEY_W-1:HASH_W] ^ in_key[HASH_W-1:0];

    // Request strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_req <= 1'b0;
        end else begin
            out_req <= in_req;
        end
    end

    // Hash and context travel with the strobe
    always_ff @(posedge clk) begin
        out_hash <= fold;
        out_ctx  <= in_ctx;
    end

    // Upstream strobe must be clean once out of reset
    a_req_known : assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(out_req))
        else $error("hash unit request strobe unknown");

endmodule : htable_hash

// ==== src/htable_ctrl.sv ====
`timescale 1ns/10ps

module htable_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    // Hashed update from the update hash unit
    input  logic                upd_req,
    input  htable_pkg::hash_t   upd_hash,
    input  db_pkg::update_req_t upd,
    // Status and ready levels
    output logic                init_done,
    output logic                upd_rdy,
    output logic                lkp_rdy,
    output logic                upd_ack,
    // Memory write port
    output logic                wr_en,
    output db_pkg::mem_wr_t     wr
);
    import htable_pkg::*;
    import db_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    hash_t       sweep_cnt;
    logic        sweep_last;
    logic        upd_wr;
    entry_t      upd_entry;

    // ---------------------------------------------------------------------
    // State machine
    // ---------------------------------------------------------------------

    // Last slot of the clear sweep
    assign sweep_last = (sweep_cnt == hash_t'(TABLE_SIZE - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_RESET: begin
                state_nxt = ST_INIT;
            end
            ST_INIT: begin
                if (sweep_last) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                state_nxt = ST_RUN;
            end
            default: begin
                state_nxt = ST_RESET;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    // Sweep address, one slot per cycle in ST_INIT
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_cnt <= '0;
        end else if (state == ST_INIT) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    // Ready once the table is clear
    assign init_done = (state == ST_RUN);
    assign upd_rdy   = init_done;
    assign lkp_rdy   = init_done;

    // ---------------------------------------------------------------------
    // Write port
    // ---------------------------------------------------------------------
    assign upd_wr = upd_req && (state == ST_RUN);

    // Delete leaves an all-zero slot
    always_comb begin
        upd_entry = '0;
        if (upd.op == OP_INSERT) begin
            upd_entry.valid = 1'b1;
            upd_entry.key   = upd.key;
            upd_entry.value = upd.value;
        end
    end

    // Clear during init, hashed update afterwards
    always_comb begin
        wr_en = 1'b0;
        wr    = '0;
        if (state == ST_INIT) begin
            wr_en   = 1'b1;
            wr.addr = sweep_cnt;
        end else if (upd_wr) begin
            wr_en   = 1'b1;
            wr.addr = upd_hash;
            wr.data = upd_entry;
        end
    end

    // Ack on the cycle after the write edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upd_ack <= 1'b0;
        end else begin
            upd_ack <= upd_wr;
        end
    end

    // Application only issues updates while upd_rdy is high
    a_upd_in_run : assert property (@(posedge clk) disable iff (!arst_n)
        upd_req |-> (state == ST_RUN))
        else $error("hashed update arrived before init completed");

endmodule : htable_ctrl

// ==== src/htable_mem.sv ====
`timescale 1ns/10ps

module htable_mem (
    input  logic               clk,
    // Write port
    input  logic               wr_en,
    input  db_pkg::mem_wr_t    wr,
    // Read port
    input  logic               rd_en,
    input  htable_pkg::hash_t  rd_addr,
    output htable_pkg::entry_t rd_data,
    output logic               rd_vld
);
    import htable_pkg::*;

    entry_t mem [TABLE_SIZE];

    // Read-first
    // Same-edge write to the read slot is seen by the next read only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr.addr] <= wr.data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Data valid one cycle after the strobe
    always_ff @(posedge clk) begin
        rd_vld <= rd_en;
    end

    // Controller must present a resolved address
    a_wr_addr_known : assert property (@(posedge clk)
        wr_en |-> !$isunknown(wr.addr))
        else $error("write address unknown while wr_en is high");

endmodule : htable_mem

// ==== src/htable_lookup_resp.sv ====
`timescale 1ns/10ps

module htable_lookup_resp (
    input  logic                 clk,
    input  logic                 arst_n,
    // Read result from the slot array
    input  logic                 rd_vld,
    input  htable_pkg::entry_t   rd_data,
    // Key from the lookup hash unit, one cycle ahead of rd_data
    input  htable_pkg::key_t     hashed_key,
    // Response to the application
    output logic                 lkp_ack,
    output db_pkg::lookup_resp_t lkp_resp
);
    import htable_pkg::*;

    key_t key_d;
    logic key_match;
    logic hit;

    // ---------------------------------------------------------------------
    // Key alignment
    // ---------------------------------------------------------------------

    // Captured on the same edge the memory reads
    always_ff @(posedge clk) begin
        key_d <= hashed_key;
    end

    // ---------------------------------------------------------------------
    // Compare and respond
    // ---------------------------------------------------------------------
    assign key_match = (rd_data.key == key_d);

    // Colliding key or empty slot reads as a miss
    assign hit = rd_data.valid && key_match;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lkp_ack  <= 1'b0;
            lkp_resp <= '0;
        end else begin
            lkp_ack        <= rd_vld;
            lkp_resp.hit   <= rd_vld && hit;
            // Zero value on a miss
            lkp_resp.value <= (rd_vld && hit) ? rd_data.value : '0;
        end
    end

    // Every slot read was cleared by the init sweep
    a_rd_valid_known : assert property (@(posedge clk) disable iff (!arst_n)
        rd_vld |-> !$isunknown(rd_data.valid))
        else $error("lookup read returned a slot that was never cleared");

endmodule : htable_lookup_resp

// ==== src/htable_top.sv ====
`timescale 1ns/10ps

module htable_top (
    input  logic                 clk,
    input  logic                 arst_n,
    output logic                 init_done,
    // Update channel
    input  logic                 upd_req,
    input  db_pkg::update_req_t  upd,
    output logic                 upd_rdy,
    output logic                 upd_ack,
    // Lookup channel
    input  logic                 lkp_req,
    input  db_pkg::lookup_req_t  lkp,
    output logic                 lkp_rdy,
    output logic                 lkp_ack,
    output db_pkg::lookup_resp_t lkp_resp
);
    import htable_pkg::*;
    import db_pkg::*;

    // Hashed update path
    logic        upd_h_req;
    hash_t       upd_h_hash;
    update_req_t upd_h_ctx;

    // Hashed lookup path
    update_req_t lkp_ctx;
    logic        lkp_h_req;
    hash_t       lkp_h_hash;
    update_req_t lkp_h_ctx;

    // Memory ports
    logic        wr_en;
    mem_wr_t     wr;
    entry_t      rd_data;
    logic        rd_vld;

    // Lookup carries only its key through the hash stage
    assign lkp_ctx.op    = op_e'(1'b0);
    assign lkp_ctx.key   = lkp.key;
    assign lkp_ctx.value = '0;

    // ---------------------------------------------------------------------
    // Hash units
    // ---------------------------------------------------------------------
    htable_hash u_upd_hash (
        .clk      ( clk ),
        .arst_n   ( arst_n ),
        .in_req   ( upd_req ),
        .in_key   ( upd.key ),
        .in_ctx   ( upd ),
        .out_req  ( upd_h_req ),
        .out_hash ( upd_h_hash ),
        .out_ctx  ( upd_h_ctx )
    );

    htable_hash u_lkp_hash (
        .clk      ( clk ),
        .arst_n   ( arst_n ),
        .in_req   ( lkp_req ),
        .in_key   ( lkp.key ),
        .in_ctx   ( lkp_ctx ),
        .out_req  ( lkp_h_req ),
        .out_hash ( lkp_h_hash ),
        .out_ctx  ( lkp_h_ctx )
    );

    // ---------------------------------------------------------------------
    // Controller, table and lookup response
    // ---------------------------------------------------------------------
    htable_ctrl u_ctrl (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .upd_req   ( upd_h_req ),
        .upd_hash  ( upd_h_hash ),
        .upd       ( upd_h_ctx ),
        .init_done ( init_done ),
        .upd_rdy   ( upd_rdy ),
        .lkp_rdy   ( lkp_rdy ),
        .upd_ack   ( upd_ack ),
        .wr_en     ( wr_en ),
        .wr        ( wr )
    );

    htable_mem u_mem (
        .clk     ( clk ),
        .wr_en   ( wr_en ),
        .wr      ( wr ),
        .rd_en   ( lkp_h_req ),
        .rd_addr ( lkp_h_hash ),
        .rd_data ( rd_data ),
        .rd_vld  ( rd_vld )
    );

    htable_lookup_resp u_resp (
        .clk        ( clk ),
        .arst_n     ( arst_n ),
        .rd_vld     ( rd_vld ),
        .rd_data    ( rd_data ),
        .hashed_key ( lkp_h_ctx.key ),
        .lkp_ack    ( lkp_ack ),
        .lkp_resp   ( lkp_resp )
    );

endmodule : htable_top

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);
    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for 8 cycles, released away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule : tb_clkgen

// ==== bench/tb_htable.sv ====
`timescale 1ns/10ps

module tb_htable;
    import htable_pkg::*;
    import db_pkg::*;

    logic         clk;
    logic         arst_n;
    logic         init_done;
    logic         upd_req;
    update_req_t  upd;
    logic         upd_rdy;
    logic         upd_ack;
    logic         lkp_req;
    lookup_req_t  lkp;
    logic         lkp_rdy;
    logic         lkp_ack;
    lookup_resp_t lkp_resp;

    // Reference model, one slot per XOR-fold
    logic   model_valid [TABLE_SIZE];
    key_t   model_key   [TABLE_SIZE];
    value_t model_value [TABLE_SIZE];

    // Keys in groups of 4 sharing one hash
    key_t key_pool [32];

    // In-flight expectations, oldest first
    int           upd_due_q [$];
    int           lkp_due_q [$];
    lookup_resp_t lkp_exp_q [$];
    key_t         lkp_key_q [$];

    int cyc = 0;
    int seed;

    tb_clkgen u_clkgen (
        .clk    ( clk ),
        .arst_n ( arst_n )
    );

    htable_top uut (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .init_done ( init_done ),
        .upd_req   ( upd_req ),
        .upd       ( upd ),
        .upd_rdy   ( upd_rdy ),
        .upd_ack   ( upd_ack ),
        .lkp_req   ( lkp_req ),
        .lkp       ( lkp ),
        .lkp_rdy   ( lkp_rdy ),
        .lkp_ack   ( lkp_ack ),
        .lkp_resp  ( lkp_resp )
    );

    // Rising edges seen so far
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ---------------------------------------------------------------------
    // Error exits and compare
    // ---------------------------------------------------------------------
    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_error($sformatf("[FAIL] %0d ns: %s, got %0h expected %0h",
                                      $time, what, actual, expected));
        end
    endtask

    // Slot index, high byte XOR low byte
    function automatic hash_t slot_of(input key_t k);
        return k[KEY_W-1:HASH_W] ^ k[HASH_W-1:0];
    endfunction

    // ---------------------------------------------------------------------
    // Ack monitor, called on every falling edge
    // ---------------------------------------------------------------------
    task automatic check_outputs();
        int           due;
        lookup_resp_t pred;
        key_t         k;
        if (upd_ack === 1'b1) begin
            if (upd_due_q.size() == 0) begin
                stop_with_error("update ack arrived with no update request in flight");
            end
            due = upd_due_q.pop_front();
            check_value(32'(cyc), 32'(due), "update ack cycle");
        end else if (upd_due_q.size() != 0 && upd_due_q[0] <= cyc) begin
            stop_with_error("update ack missing for an accepted update request");
        end
        if (lkp_ack === 1'b1) begin
            if (lkp_due_q.size() == 0) begin
                stop_with_error("lookup ack arrived with no lookup request in flight");
            end
            due  = lkp_due_q.pop_front();
            pred = lkp_exp_q.pop_front();
            k    = lkp_key_q.pop_front();
            check_value(32'(cyc), 32'(due), "lookup ack cycle");
            check_value(32'(lkp_resp.hit), 32'(pred.hit),
                        $sformatf("lookup hit for key %h", k));
            check_value(32'(lkp_resp.value), 32'(pred.value),
                        $sformatf("lookup value for key %h", k));
        end else if (lkp_due_q.size() != 0 && lkp_due_q[0] <= cyc) begin
            stop_with_error("lookup ack missing for an accepted lookup request");
        end
    endtask

    // ---------------------------------------------------------------------
    // One cycle of stimulus
    // ---------------------------------------------------------------------
    task automatic drive_cycle(input logic do_upd, input op_e op, input key_t ukey,
                               input value_t uval, input logic do_lkp, input key_t lkey);
        lookup_resp_t pred;
        hash_t        s;
        @(negedge clk);
        check_outputs();
        // Ready levels stay high once init is done
        check_value(32'({init_done, upd_rdy, lkp_rdy}), 32'(3'b111),
                    "ready levels after init");
        upd_req = 1'b0;
        upd     = '0;
        lkp_req = 1'b0;
        lkp     = '0;
        // Lookup sees the model before this cycle's update
        if (do_lkp) begin
            s          = slot_of(lkey);
            pred.hit   = model_valid[s] && (model_key[s] == lkey);
            pred.value = pred.hit ? model_value[s] : '0;
            lkp_req    = 1'b1;
            lkp.key    = lkey;
            lkp_exp_q.push_back(pred);
            lkp_key_q.push_back(lkey);
            // Sampled next edge, response 3 edges later
            lkp_due_q.push_back(cyc + 3);
        end
        if (do_upd) begin
            s              = slot_of(ukey);
            model_valid[s] = (op == OP_INSERT);
            model_key[s]   = (op == OP_INSERT) ? ukey : '0;
            model_value[s] = (op == OP_INSERT) ? uval : '0;
            upd_req        = 1'b1;
            upd.op         = op;
            upd.key        = ukey;
            upd.value      = uval;
            upd_due_q.push_back(cyc + 2);
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, OP_INSERT, '0, '0, 1'b0, '0);
    endtask

    task automatic send_update(input op_e op, input key_t k, input value_t v);
        drive_cycle(1'b1, op, k, v, 1'b0, '0);
    endtask

    task automatic send_lookup(input key_t k);
        drive_cycle(1'b0, OP_INSERT, '0, '0, 1'b1, k);
    endtask

    // Idle until nothing is in flight, then a few more for stray acks
    task automatic drain();
        int n;
        n = 0;
        while (upd_due_q.size() != 0 || lkp_due_q.size() != 0) begin
            idle_cycle();
            n++;
            if (n > 16) begin
                stop_with_error("timeout waiting for outstanding acks");
            end
        end
        repeat (4) idle_cycle();
    endtask

    // ---------------------------------------------------------------------
    // Reset and init sweep
    // ---------------------------------------------------------------------
    task automatic wait_init();
        int n;
        n = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            check_value(32'({init_done, upd_rdy, lkp_rdy}), 32'(0), "ready levels in reset");
            check_value(32'({upd_ack, lkp_ack, lkp_resp.hit}), 32'(0), "acks in reset");
            n++;
            if (n > 32) begin
                stop_with_error("timeout waiting for reset release");
            end
        end
        n = 0;
        while (init_done !== 1'b1) begin
            @(negedge clk);
            check_outputs();
            // All three levels move together
            check_value(32'(upd_rdy), 32'(init_done), "upd_rdy during init");
            check_value(32'(lkp_rdy), 32'(init_done), "lkp_rdy during init");
            n++;
            if (n > TABLE_SIZE + 16) begin
                stop_with_error("timeout waiting for init_done after reset");
            end
        end
        if (n < TABLE_SIZE) begin
            stop_with_error("init_done rose before every slot could be cleared");
        end
    endtask

    // ---------------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [7:0]  lo;
        key_t        ka;
        key_t        kb;
        upd_req = 1'b0;
        upd     = '0;
        lkp_req = 1'b0;
        lkp     = '0;
        seed    = 31627;
        for (int i = 0; i < TABLE_SIZE; i++) begin
            model_valid[i] = 1'b0;
            model_key[i]   = '0;
            model_value[i] = '0;
        end
        // Group g folds to 29*g+7
        for (int g = 0; g < 8; g++) begin
            for (int j = 0; j < 4; j++) begin
                lo                 = 8'(j * 53 + g * 11);
                key_pool[g*4 + j] = {lo ^ 8'(g * 29 + 7), lo};
            end
        end
        ka = key_pool[0];
        kb = key_pool[1];

        wait_init();

        // Empty table
        for (int i = 0; i < 32; i++) begin
            send_lookup(key_pool[i]);
        end
        drain();

        // Insert then lookup
        send_update(OP_INSERT, ka, 16'h1234);
        idle_cycle();
        send_lookup(ka);
        drain();

        // Delete, colliding key, replacement
        send_update(OP_DELETE, ka, '0);
        send_lookup(ka);
        send_update(OP_INSERT, ka, 16'h5a5a);
        send_lookup(kb);
        send_update(OP_INSERT, kb, 16'hbeef);
        send_lookup(ka);
        send_lookup(kb);
        drain();

        // Same slot on the same cycle reads the old entry
        drive_cycle(1'b1, OP_INSERT, ka, 16'h7777, 1'b1, kb);
        drive_cycle(1'b1, OP_DELETE, ka, '0, 1'b1, ka);
        send_lookup(ka);
        drain();

        // Random traffic on both channels
        for (int i = 0; i < 2000; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            drive_cycle(r[2:0] != 3'd0, (r[7:6] == 2'b11) ? OP_DELETE : OP_INSERT,
                        key_pool[r[12:8]], r2[15:0], r[5:3] != 3'd0, key_pool[r[17:13]]);
        end
        drain();

        $display("TEST OK");
        $finish;
    end

endmodule : tb_htable

// ==== all.f ====
src/htable_pkg.sv
src/db_pkg.sv
src/htable_hash.sv
src/htable_ctrl.sv
src/htable_mem.sv
src/htable_lookup_resp.sv
src/htable_top.sv
bench/tb_clkgen.sv
bench/tb_htable.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the hash table testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_htable \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

echo "Simulation passed"
exit 0
